//--- hw/rvc_pkg.sv
// -------------------------------------------------
// rvc package
// widths, RV32 and RVC encodings and the lane and
// slot records shared by the fetch-decode front end
// -------------------------------------------------

`default_nettype none

package rvc_pkg;

  // fetch block geometry
  localparam int PARCEL_W    = 16;
  localparam int INSTR_W     = 32;
  localparam int NUM_PARCELS = 4;
  localparam int FETCH_W     = PARCEL_W * NUM_PARCELS;
  localparam int SLOT_CNT_W  = 3;

  localparam logic [4:0] REG_SP = 5'd2;
  localparam logic [4:0] REG_RA = 5'd1;

  // -----------------------------------------------
  // encodings
  // -----------------------------------------------
  // low two bits of a parcel, 2'b11 marks a 32-bit instruction
  typedef enum logic [1:0] {
    Q_C0   = 2'b00,
    Q_C1   = 2'b01,
    Q_C2   = 2'b10,
    Q_FULL = 2'b11
  } rvc_quadrant_e;

  typedef enum logic [2:0] {
    F3_C0_ADDI4SPN = 3'b000,
    F3_C0_LW       = 3'b010,
    F3_C0_SW       = 3'b110
  } c0_funct3_e;

  typedef enum logic [2:0] {
    F3_C1_ADDI     = 3'b000,
    F3_C1_JAL      = 3'b001,
    F3_C1_LI       = 3'b010,
    F3_C1_LUI_SP   = 3'b011,
    F3_C1_MISC_ALU = 3'b100,
    F3_C1_J        = 3'b101,
    F3_C1_BEQZ     = 3'b110,
    F3_C1_BNEZ     = 3'b111
  } c1_funct3_e;

  typedef enum logic [2:0] {
    F3_C2_SLLI     = 3'b000,
    F3_C2_LWSP     = 3'b010,
    F3_C2_JR_MV    = 3'b100,
    F3_C2_SWSP     = 3'b110
  } c2_funct3_e;

  typedef enum logic [6:0] {
    OPC_LOAD   = 7'b0000011,
    OPC_OP_IMM = 7'b0010011,
    OPC_STORE  = 7'b0100011,
    OPC_OP     = 7'b0110011,
    OPC_LUI    = 7'b0110111,
    OPC_BRANCH = 7'b1100011,
    OPC_JALR   = 7'b1100111,
    OPC_JAL    = 7'b1101111,
    OPC_SYSTEM = 7'b1110011
  } base_opcode_e;

  localparam logic [INSTR_W-1:0] EBREAK_INSTR = {12'h001, 5'd0, 3'b000, 5'd0, OPC_SYSTEM};

  // -----------------------------------------------
  // lane and slot records
  // -----------------------------------------------
  // parcel at the lane's own position sits in the low half
  typedef struct packed {
    logic [PARCEL_W-1:0] next_parcel;
    logic [PARCEL_W-1:0] own_parcel;
  } lane_in_t;

  typedef struct packed {
    logic [INSTR_W-1:0] instr;
    logic               is_compressed;
    logic               illegal;
  } lane_out_t;

  typedef struct packed {
    logic      valid;
    lane_out_t lane;
  } slot_t;

endpackage

`default_nettype wire

//--- hw/rvc_fetch_splitter.sv
// -------------------------------------------------
// fetch splitter
// captures a fetch block and forms one overlapping
// parcel pair per lane
// -------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module rvc_fetch_splitter (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          fetch_valid_i,
  input  logic [rvc_pkg::FETCH_W-1:0]   fetch_block_i,
  output rvc_pkg::lane_in_t             lanes_o [rvc_pkg::NUM_PARCELS],
  output logic                          blk_valid_o
);

  logic [rvc_pkg::FETCH_W-1:0] blk_q;

  // block payload, held while no new block arrives
  always_ff @(posedge clk_i) begin
    if (fetch_valid_i) begin
      blk_q <= fetch_block_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      blk_valid_o <= 1'b0;
    end else begin
      blk_valid_o <= fetch_valid_i;
    end
  end

  // lane i sees parcel i in the low half and parcel i+1 above it
  for (genvar g = 0; g < rvc_pkg::NUM_PARCELS; g++) begin : g_lane
    assign lanes_o[g].own_parcel = blk_q[g*rvc_pkg::PARCEL_W +: rvc_pkg::PARCEL_W];
    if (g == rvc_pkg::NUM_PARCELS - 1) begin : g_last
      // nothing follows the last parcel inside this block
      assign lanes_o[g].next_parcel = '0;
    end else begin : g_mid
      assign lanes_o[g].next_parcel = blk_q[(g+1)*rvc_pkg::PARCEL_W +: rvc_pkg::PARCEL_W];
    end
  end

endmodule

`default_nettype wire

//--- hw/rvc_expander.sv
// -------------------------------------------------
// lane expander
// expands one RV32C parcel to its RV32I form, passes
// full instructions through and flags illegal codes
// -------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module rvc_expander (
  input  rvc_pkg::lane_in_t  lane_i,
  output rvc_pkg::lane_out_t lane_o
);

  logic [rvc_pkg::INSTR_W-1:0] raw;
  logic [rvc_pkg::INSTR_W-1:0] instr;
  logic                        illegal;
  logic                        is_compressed;
  // rd'/rs2' field of the CIW, CL, CS and CA formats
  logic [4:0]                  rd_c;
  // rs1'/rd' field of the CL, CS, CB and CA formats
  logic [4:0]                  rs1_c;
  // full rd/rs1 field of the CR and CI formats
  logic [4:0]                  rd_f;

  assign raw   = {lane_i.next_parcel, lane_i.own_parcel};
  assign rd_c  = {2'b01, raw[4:2]};
  assign rs1_c = {2'b01, raw[9:7]};
  assign rd_f  = raw[11:7];

  always_comb begin
    instr         = raw;
    illegal       = 1'b0;
    is_compressed = 1'b1;

    unique case (rvc_pkg::rvc_quadrant_e'(raw[1:0]))
      // ---------------------------------------------
      // quadrant 0
      // ---------------------------------------------
      rvc_pkg::Q_C0: begin
        unique case (raw[15:13])
          rvc_pkg::F3_C0_ADDI4SPN: begin
            // addi rd', sp, nzuimm
            instr = {2'b00, raw[10:7], raw[12:11], raw[5], raw[6], 2'b00,
                     rvc_pkg::REG_SP, 3'b000, rd_c, rvc_pkg::OPC_OP_IMM};
            illegal = (raw[12:5] == 8'd0);
          end
          rvc_pkg::F3_C0_LW: begin
            instr = {5'd0, raw[5], raw[12:10], raw[6], 2'b00,
                     rs1_c, 3'b010, rd_c, rvc_pkg::OPC_LOAD};
          end
          rvc_pkg::F3_C0_SW: begin
            instr = {5'd0, raw[5], raw[12], rd_c, rs1_c, 3'b010,
                     raw[11:10], raw[6], 2'b00, rvc_pkg::OPC_STORE};
          end
          default: begin
            illegal = 1'b1;
          end
        endcase
      end

      // ---------------------------------------------
      // quadrant 1
      // ---------------------------------------------
      rvc_pkg::Q_C1: begin
        unique case (raw[15:13])
          rvc_pkg::F3_C1_ADDI: begin
            // also covers c.nop
            instr = {{6{raw[12]}}, raw[12], raw[6:2], rd_f, 3'b000, rd_f,
                     rvc_pkg::OPC_OP_IMM};
          end
          rvc_pkg::F3_C1_JAL, rvc_pkg::F3_C1_J: begin
            // funct3[2] clear means c.jal, which links to ra
            instr = {raw[12], raw[8], raw[10:9], raw[6], raw[7], raw[2], raw[11],
                     raw[5:3], {9{raw[12]}},
                     raw[15] ? 5'd0 : rvc_pkg::REG_RA, rvc_pkg::OPC_JAL};
          end
          rvc_pkg::F3_C1_LI: begin
            instr = {{6{raw[12]}}, raw[12], raw[6:2], 5'd0, 3'b000, rd_f,
                     rvc_pkg::OPC_OP_IMM};
          end
          rvc_pkg::F3_C1_LUI_SP: begin
            if (rd_f == rvc_pkg::REG_SP) begin
              // c.addi16sp, immediate scaled by 16
              instr = {{3{raw[12]}}, raw[4:3], raw[5], raw[2], raw[6], 4'd0,
                       rvc_pkg::REG_SP, 3'b000, rvc_pkg::REG_SP, rvc_pkg::OPC_OP_IMM};
            end else begin
              instr = {{15{raw[12]}}, raw[6:2], rd_f, rvc_pkg::OPC_LUI};
            end
            illegal = ({raw[12], raw[6:2]} == 6'd0);
          end
          rvc_pkg::F3_C1_MISC_ALU: begin
            unique case (raw[11:10])
              2'b00, 2'b01: begin
                // srli or srai, bit 10 picks the arithmetic form
                instr = {1'b0, raw[10], 4'd0, raw[12], raw[6:2], rs1_c, 3'b101,
                         rs1_c, rvc_pkg::OPC_OP_IMM};
              end
              2'b10: begin
                instr = {{6{raw[12]}}, raw[12], raw[6:2], rs1_c, 3'b111, rs1_c,
                         rvc_pkg::OPC_OP_IMM};
              end
              default: begin
                // register-register group, bit 12 set is RV64 only
                unique case ({raw[12], raw[6:5]})
                  3'b000: begin
                    instr = {7'b0100000, rd_c, rs1_c, 3'b000, rs1_c, rvc_pkg::OPC_OP};
                  end
                  3'b001: begin
                    instr = {7'd0, rd_c, rs1_c, 3'b100, rs1_c, rvc_pkg::OPC_OP};
                  end
                  3'b010: begin
                    instr = {7'd0, rd_c, rs1_c, 3'b110, rs1_c, rvc_pkg::OPC_OP};
                  end
                  3'b011: begin
                    instr = {7'd0, rd_c, rs1_c, 3'b111, rs1_c, rvc_pkg::OPC_OP};
                  end
                  default: begin
                    illegal = 1'b1;
                  end
                endcase
              end
            endcase
          end
          default: begin
            // beqz and bnez differ only in funct3[0]
            instr = {{4{raw[12]}}, raw[6:5], raw[2], 5'd0, rs1_c, 2'b00, raw[13],
                     raw[11:10], raw[4:3], raw[12], rvc_pkg::OPC_BRANCH};
          end
        endcase
      end

      // ---------------------------------------------
      // quadrant 2
      // ---------------------------------------------
      rvc_pkg::Q_C2: begin
        unique case (raw[15:13])
          rvc_pkg::F3_C2_SLLI: begin
            instr = {6'd0, raw[12], raw[6:2], rd_f, 3'b001, rd_f, rvc_pkg::OPC_OP_IMM};
          end
          rvc_pkg::F3_C2_LWSP: begin
            instr = {4'd0, raw[3:2], raw[12], raw[6:4], 2'b00, rvc_pkg::REG_SP,
                     3'b010, rd_f, rvc_pkg::OPC_LOAD};
            illegal = (rd_f == 5'd0);
          end
          rvc_pkg::F3_C2_JR_MV: begin
            if (!raw[12]) begin
              if (raw[6:2] == 5'd0) begin
                // c.jr
                instr   = {12'd0, rd_f, 3'b000, 5'd0, rvc_pkg::OPC_JALR};
                illegal = (rd_f == 5'd0);
              end else begin
                // c.mv
                instr = {7'd0, raw[6:2], 5'd0, 3'b000, rd_f, rvc_pkg::OPC_OP};
              end
            end else if (raw[6:2] != 5'd0) begin
              // c.add
              instr = {7'd0, raw[6:2], rd_f, 3'b000, rd_f, rvc_pkg::OPC_OP};
            end else if (rd_f == 5'd0) begin
              instr = rvc_pkg::EBREAK_INSTR;
            end else begin
              // c.jalr
              instr = {12'd0, rd_f, 3'b000, rvc_pkg::REG_RA, rvc_pkg::OPC_JALR};
            end
          end
          rvc_pkg::F3_C2_SWSP: begin
            instr = {4'd0, raw[8:7], raw[12], raw[6:2], rvc_pkg::REG_SP, 3'b010,
                     raw[11:9], 2'b00, rvc_pkg::OPC_STORE};
          end
          default: begin
            illegal = 1'b1;
          end
        endcase
      end

      // full 32-bit instruction
      rvc_pkg::Q_FULL: begin
        is_compressed = 1'b0;
      end
    endcase
  end

  // an illegal lane hands back the word it was given
  assign lane_o.instr         = illegal ? raw : instr;
  assign lane_o.is_compressed = is_compressed;
  assign lane_o.illegal       = illegal;

endmodule

`default_nettype wire

//--- hw/rvc_slot_packer.sv
// -------------------------------------------------
// slot packer
// walks the parcels from parcel 0, keeps the lanes
// where an instruction starts and packs them into
// consecutive registered slots
// -------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module rvc_slot_packer (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic                              blk_valid_i,
  input  rvc_pkg::lane_out_t                lanes_i [rvc_pkg::NUM_PARCELS],
  output rvc_pkg::slot_t                    slots_o [rvc_pkg::NUM_PARCELS],
  output logic [rvc_pkg::SLOT_CNT_W-1:0]    slot_count_o,
  output logic                              out_valid_o,
  output logic                              incomplete_o
);

  logic [rvc_pkg::NUM_PARCELS-1:0]   start_d;
  logic [rvc_pkg::NUM_PARCELS-1:0]   valid_d;
  logic [rvc_pkg::NUM_PARCELS-1:0]   valid_q;
  rvc_pkg::lane_out_t                lane_d [rvc_pkg::NUM_PARCELS];
  rvc_pkg::lane_out_t                lane_q [rvc_pkg::NUM_PARCELS];
  logic [rvc_pkg::SLOT_CNT_W-1:0]    cnt_d;
  logic                              incomplete_d;

  // -----------------------------------------------
  // start mask, a full instruction covers two parcels
  // -----------------------------------------------
  always_comb begin
    logic skip;
    start_d      = '0;
    incomplete_d = 1'b0;
    skip         = 1'b0;
    for (int i = 0; i < rvc_pkg::NUM_PARCELS; i++) begin
      if (skip) begin
        skip = 1'b0;
      end else if (!lanes_i[i].is_compressed && i == rvc_pkg::NUM_PARCELS - 1) begin
        // second half lives in the next block, drop it
        incomplete_d = 1'b1;
      end else begin
        start_d[i] = 1'b1;
        skip       = !lanes_i[i].is_compressed;
      end
    end
  end

  // compaction of the start lanes into slots 0 onward
  always_comb begin
    valid_d = '0;
    cnt_d   = '0;
    for (int i = 0; i < rvc_pkg::NUM_PARCELS; i++) begin
      lane_d[i] = '0;
    end
    for (int i = 0; i < rvc_pkg::NUM_PARCELS; i++) begin
      if (start_d[i]) begin
        // the count cannot pass the last slot before the loop ends
        lane_d[cnt_d[1:0]]  = lanes_i[i];
        valid_d[cnt_d[1:0]] = 1'b1;
        cnt_d               = cnt_d + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q      <= '0;
      slot_count_o <= '0;
      out_valid_o  <= 1'b0;
      incomplete_o <= 1'b0;
    end else begin
      valid_q      <= blk_valid_i ? valid_d : '0;
      slot_count_o <= blk_valid_i ? cnt_d : '0;
      out_valid_o  <= blk_valid_i;
      incomplete_o <= blk_valid_i & incomplete_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (blk_valid_i) begin
      lane_q <= lane_d;
    end
  end

  for (genvar g = 0; g < rvc_pkg::NUM_PARCELS; g++) begin : g_slot
    assign slots_o[g].valid = valid_q[g];
    assign slots_o[g].lane  = lane_q[g];
  end

endmodule

`default_nettype wire

//--- hw/rvc_fetch_decode.sv
// -------------------------------------------------
// fetch-block decode front end
// splits a 64-bit fetch block into four lanes,
// expands each lane and packs the starts into slots
// -------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module rvc_fetch_decode (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic                              fetch_valid_i,
  input  logic [rvc_pkg::FETCH_W-1:0]       fetch_block_i,
  output rvc_pkg::slot_t                    slots_o [rvc_pkg::NUM_PARCELS],
  output logic [rvc_pkg::SLOT_CNT_W-1:0]    slot_count_o,
  output logic                              out_valid_o,
  output logic                              incomplete_o
);

  rvc_pkg::lane_in_t  lanes_in  [rvc_pkg::NUM_PARCELS];
  rvc_pkg::lane_out_t lanes_out [rvc_pkg::NUM_PARCELS];
  logic               blk_valid;

  // stage 1, registered block
  rvc_fetch_splitter u_splitter (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .fetch_valid_i (fetch_valid_i),
    .fetch_block_i (fetch_block_i),
    .lanes_o       (lanes_in),
    .blk_valid_o   (blk_valid)
  );

  for (genvar g = 0; g < rvc_pkg::NUM_PARCELS; g++) begin : g_lane
    rvc_expander u_expander (
      .lane_i (lanes_in[g]),
      .lane_o (lanes_out[g])
    );
  end

  // stage 2, registered slots
  rvc_slot_packer u_packer (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .blk_valid_i  (blk_valid),
    .lanes_i      (lanes_out),
    .slots_o      (slots_o),
    .slot_count_o (slot_count_o),
    .out_valid_o  (out_valid_o),
    .incomplete_o (incomplete_o)
  );

endmodule

`default_nettype wire

//--- verif/rvc_fetch_decode_checker.sv
// -------------------------------------------------
// fetch-decode checker
// concurrent assertions on the top-level outputs,
// bound into the fetch-decode top level
// -------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module rvc_fetch_decode_checker (
  input logic                              clk_i,
  input logic                              rst_n_i,
  input logic                              fetch_valid_i,
  input rvc_pkg::slot_t                    slots_o [rvc_pkg::NUM_PARCELS],
  input logic [rvc_pkg::SLOT_CNT_W-1:0]    slot_count_o,
  input logic                              out_valid_o,
  input logic                              incomplete_o
);

  int unsigned                     fail_count = 0;
  logic [rvc_pkg::NUM_PARCELS-1:0] slot_valid;

  for (genvar g = 0; g < rvc_pkg::NUM_PARCELS; g++) begin : g_valid
    assign slot_valid[g] = slots_o[g].valid;
  end

  // all outputs idle in the cycle after a reset edge
  a_reset_idle: assert property (@(posedge clk_i)
    !rst_n_i |=> (slot_valid == '0 && !out_valid_o && !incomplete_o && slot_count_o == '0))
    else begin
      fail_count = fail_count + 1;
      $error("outputs not idle after reset");
    end

  // two register stages between input strobe and output strobe
  a_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_o == $past(fetch_valid_i, 2))
    else begin
      fail_count = fail_count + 1;
      $error("out_valid_o does not follow fetch_valid_i by two cycles");
    end

  a_count: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    slot_count_o == $countones(slot_valid))
    else begin
      fail_count = fail_count + 1;
      $error("slot_count_o differs from the number of valid slots");
    end

  a_incomplete: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    incomplete_o |-> out_valid_o)
    else begin
      fail_count = fail_count + 1;
      $error("incomplete_o without out_valid_o");
    end

endmodule

bind rvc_fetch_decode rvc_fetch_decode_checker u_checker (
  .clk_i         (clk_i),
  .rst_n_i       (rst_n_i),
  .fetch_valid_i (fetch_valid_i),
  .slots_o       (slots_o),
  .slot_count_o  (slot_count_o),
  .out_valid_o   (out_valid_o),
  .incomplete_o  (incomplete_o)
);

`default_nettype wire

//--- verif/tb_rvc_fetch_decode.sv
// -------------------------------------------------
// fetch-decode testbench
// directed fetch blocks checked against hand-encoded
// RV32 expansions, slot packing and pipeline timing
// -------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module tb_rvc_fetch_decode;

  localparam int CLK_PERIOD = 100;
  localparam int NUM_BLOCKS = 11;
  localparam int MARGIN     = 10;

  // test blocks, parcel 0 in the low bits
  // c.sub x8,x9 | c.slli x10,3 | c.addi x8,1 | c.lw x8,4(x9)
  localparam logic [63:0] BLK_COMP      = 64'h8C05_050E_0405_40C0;
  // c.li x5,-1 | add x1,x2,x3 | c.addi x8,1
  localparam logic [63:0] BLK_MIXED     = 64'h52FD_0031_00B3_0405;
  // reserved C0 | c.jr x0 | c.lwsp x0 | c.addi4spn with zero imm
  localparam logic [63:0] BLK_ILLEGAL   = 64'h8044_8002_4012_0004;
  // c.addi16sp 16 | c.mv x10,x11 | c.jalr x5 | c.ebreak
  localparam logic [63:0] BLK_SPECIAL_A = 64'h6141_852E_9282_9002;
  // c.nop | c.jal +16 | c.beqz x8,+4 | c.j +8
  localparam logic [63:0] BLK_SPECIAL_B = 64'h0001_2801_C011_A021;

  logic                              clk;
  logic                              rst_n;
  logic                              fetch_valid;
  logic [rvc_pkg::FETCH_W-1:0]       fetch_block;
  rvc_pkg::slot_t                    slots [rvc_pkg::NUM_PARCELS];
  logic [rvc_pkg::SLOT_CNT_W-1:0]    slot_count;
  logic                              out_valid;
  logic                              incomplete;
  integer                            seed;

  rvc_fetch_decode uut (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .fetch_valid_i (fetch_valid),
    .fetch_block_i (fetch_block),
    .slots_o       (slots),
    .slot_count_o  (slot_count),
    .out_valid_o   (out_valid),
    .incomplete_o  (incomplete)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  // -----------------------------------------------
  // helpers
  // -----------------------------------------------
  task automatic check_value(input logic [31:0] act, input logic [31:0] exp,
                             input string what);
    if (act !== exp) begin
      $display("** Error at %0t ns: %s mismatch, got 0x%08h, expected 0x%08h",
               $time, what, act, exp);
      $display("Regression failed");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  // one block in, idle after it, sample two edges later on the falling edge
  task automatic send_block(input logic [63:0] blk);
    @(posedge clk);
    fetch_valid <= 1'b1;
    fetch_block <= blk;
    @(posedge clk);
    fetch_valid <= 1'b0;
    fetch_block <= {$random(seed), $random(seed)};
    @(posedge clk);
    @(negedge clk);
  endtask

  task automatic expect_slots(input logic [3:0][31:0] instrs, input logic [3:0] comp,
                              input logic [3:0] ill, input int count, input logic inc);
    check_value(32'(out_valid), 32'd1, "out_valid");
    check_value(32'(slot_count), 32'(count), "slot_count");
    check_value(32'(incomplete), 32'(inc), "incomplete");
    for (int i = 0; i < rvc_pkg::NUM_PARCELS; i++) begin
      check_value(32'(slots[i].valid), 32'(i < count), $sformatf("slot %0d valid", i));
      if (i < count) begin
        check_value(slots[i].lane.instr, instrs[i], $sformatf("slot %0d instr", i));
        check_value(32'(slots[i].lane.is_compressed), 32'(comp[i]),
                    $sformatf("slot %0d is_compressed", i));
        check_value(32'(slots[i].lane.illegal), 32'(ill[i]),
                    $sformatf("slot %0d illegal", i));
      end
    end
  endtask

  // expected results, slot 0 in the low word
  task automatic expect_comp();
    expect_slots({32'h4094_0433, 32'h0035_1513, 32'h0014_0413, 32'h0044_A403},
                 4'b1111, 4'b0000, 4, 1'b0);
  endtask

  task automatic expect_mixed();
    expect_slots({32'h0000_0000, 32'hFFF0_0293, 32'h0031_00B3, 32'h0014_0413},
                 4'b0101, 4'b0000, 3, 1'b0);
  endtask

  task automatic expect_illegal();
    expect_slots({32'h0000_8044, 32'h8044_8002, 32'h8002_4012, 32'h4012_0004},
                 4'b1111, 4'b1111, 4, 1'b0);
  endtask

  // -----------------------------------------------
  // directed tests
  // -----------------------------------------------
  task automatic all_compressed_block();
    send_block(BLK_COMP);
    expect_comp();
  endtask

  task automatic mixed_block();
    send_block(BLK_MIXED);
    expect_mixed();
  endtask

  task automatic illegal_codes();
    send_block(BLK_ILLEGAL);
    expect_illegal();
  endtask

  // ebreak, jalr links to ra, jal links to x1
  task automatic special_forms();
    send_block(BLK_SPECIAL_A);
    expect_slots({32'h0101_0113, 32'h00B0_0533, 32'h0002_80E7, rvc_pkg::EBREAK_INSTR},
                 4'b1111, 4'b0000, 4, 1'b0);
    send_block(BLK_SPECIAL_B);
    expect_slots({32'h0000_0013, 32'h0100_00EF, 32'h0004_0263, 32'h0080_006F},
                 4'b1111, 4'b0000, 4, 1'b0);
  endtask

  // full add in parcels 0-1, c.addi, then a full start on parcel 3
  task automatic straddle_block();
    logic [31:0] pad;
    pad = $random(seed);
    send_block({pad[15:2], 2'b11, 16'h0405, 32'h0031_00B3});
    expect_slots({32'h0, 32'h0, 32'h0014_0413, 32'h0031_00B3},
                 4'b0010, 4'b0000, 2, 1'b1);
  endtask

  task automatic back_to_back_and_reset();
    @(posedge clk);
    fetch_valid <= 1'b1;
    fetch_block <= BLK_COMP;
    @(posedge clk);
    fetch_block <= BLK_MIXED;
    @(posedge clk);
    fetch_block <= BLK_ILLEGAL;
    @(negedge clk);
    expect_comp();
    @(posedge clk);
    fetch_valid <= 1'b0;
    fetch_block <= {$random(seed), $random(seed)};
    @(negedge clk);
    expect_mixed();
    @(posedge clk);
    @(negedge clk);
    expect_illegal();

    // reset lands while a block sits in the splitter
    @(posedge clk);
    fetch_valid <= 1'b1;
    fetch_block <= BLK_MIXED;
    @(posedge clk);
    fetch_valid <= 1'b0;
    rst_n       <= 1'b0;
    @(posedge clk);
    @(negedge clk);
    check_value(32'(out_valid), 32'd0, "out_valid under reset");
    check_value(32'(slot_count), 32'd0, "slot_count under reset");
    @(posedge clk);
    @(posedge clk);
    rst_n <= 1'b1;
    send_block(BLK_COMP);
    expect_comp();
  endtask

  // -----------------------------------------------
  // main sequence and watchdog
  // -----------------------------------------------
  initial begin
    seed        = 32'h228d_6211;
    rst_n       = 1'b0;
    fetch_valid = 1'b0;
    fetch_block = '0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;

    all_compressed_block();
    mixed_block();
    illegal_codes();
    special_forms();
    straddle_block();
    back_to_back_and_reset();

    if (uut.u_checker.fail_count != 0) begin
      $display("Regression failed");
      $fatal(1, "assertion failures in the bound checker");
    end else begin
      $display("Regression passed");
      $finish;
    end
  end

  initial begin
    #(NUM_BLOCKS * MARGIN * CLK_PERIOD);
    $display("Watchdog expired before the tests finished");
    $display("Regression failed");
    $fatal(1, "timeout");
  end

endmodule

`default_nettype wire

//--- sim.f
hw/rvc_pkg.sv
hw/rvc_fetch_splitter.sv
hw/rvc_expander.sv
hw/rvc_slot_packer.sv
hw/rvc_fetch_decode.sv
verif/rvc_fetch_decode_checker.sv
verif/tb_rvc_fetch_decode.sv

//--- Makefile
# Verilator build and run of the fetch-decode testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_rvc_fetch_decode
FILELIST  := sim.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Regression passed

.PHONY: help test clean

help:
	@echo "available targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
		echo "test: PASS"; \
	else \
		echo "test: FAIL, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
